/* hw/la_config.svh */
`ifndef LA_CONFIG_SVH
`define LA_CONFIG_SVH

// Capture geometry
`define LA_NUM_LANES          9
`define LA_NUM_GROUPS         4
`define LA_SYNC_STAGES        2

// Register map
`define LA_REG_GROUP          4'd0
`define LA_REG_TRIGGER        4'd1
`define LA_REG_DEPTH_LO       4'd2
`define LA_REG_DEPTH_HI       4'd3
`define LA_REG_DOWNSAMPLE_LO  4'd4
`define LA_REG_DOWNSAMPLE_HI  4'd5
`define LA_REG_ARM            4'd6
`define LA_REG_MANUAL         4'd7
`define LA_REG_STATUS         4'd8

// Trigger byte fields
`define LA_TRIG_GROUP_MSB     5
`define LA_TRIG_GROUP_LSB     4
`define LA_TRIG_LANE_MSB      3
`define LA_TRIG_LANE_LSB      0
`define LA_TRIG_INVERT        7

`endif

/* hw/la_pkg.sv */
`include "la_config.svh"

package la_pkg;

   // Register port
   typedef logic [3:0] reg_addr_t;
   typedef logic [7:0] reg_data_t;

   // Probe group, 4..7 give the fixed pattern
   typedef logic [2:0] group_sel_t;

   typedef logic [7:0]  trig_sel_t;   // Group, lane and invert fields
   typedef logic [15:0] count16_t;    // Depth and downsample

   // Group g sits at bits 9g+8..9g
   typedef logic [`LA_NUM_GROUPS*`LA_NUM_LANES-1:0] probe_bus_t;

   // Older sample in the upper bit
   typedef logic [1:0] lane_hist_t;

   // Lane i at bits 2i+1..2i
   typedef logic [2*`LA_NUM_LANES-1:0] sample_word_t;

   // Four-phase handshake
   typedef enum logic [1:0] {
      IDLE,
      ACK,
      WAIT_REQ_LOW
   } hs_state_t;

endpackage

/* hw/la_if.sv */
`timescale 1ns/1ps

// Configuration from the register block to the capture path
interface la_cfg_if;

   la_pkg::group_sel_t group;        // Lane source group
   la_pkg::trig_sel_t  trig_sel;     // Trigger group, lane, invert
   la_pkg::count16_t   depth;        // Strobes per capture
   la_pkg::count16_t   downsample;   // Strobe period minus one
   logic               arm;
   logic               manual;       // Forces trigger source high

   // Register block owns every field
   modport regs (
      output group,
      output trig_sel,
      output depth,
      output downsample,
      output arm,
      output manual
   );

   modport trig (
      input trig_sel,
      input arm,
      input manual
   );

   modport ctrl (
      input depth,
      input downsample
   );

endinterface

/* hw/la_regs.sv */
`timescale 1ns/1ps
`include "la_config.svh"

module la_regs (
   input  logic              observer_clk,
   input  logic              reset,
   input  logic              reg_req,
   input  logic              reg_we,
   input  la_pkg::reg_addr_t reg_addr,
   input  la_pkg::reg_data_t reg_wdata,
   output logic              reg_ack,
   output la_pkg::reg_data_t reg_rdata,
   la_cfg_if.regs            cfg,
   input  logic              capturing,
   input  logic              capture_start,
   input  logic              overflow,
   output logic              arm_write
);

   la_pkg::hs_state_t state;
   la_pkg::reg_data_t read_mux;
   logic              do_access;

   // One access per request, taken on the first edge that sees req
   assign do_access = (state == la_pkg::IDLE) && reg_req;

   always_comb begin
      case (reg_addr)
         `LA_REG_GROUP:         read_mux = {5'b0, cfg.group};
         `LA_REG_TRIGGER:       read_mux = cfg.trig_sel;
         `LA_REG_DEPTH_LO:      read_mux = cfg.depth[7:0];
         `LA_REG_DEPTH_HI:      read_mux = cfg.depth[15:8];
         `LA_REG_DOWNSAMPLE_LO: read_mux = cfg.downsample[7:0];
         `LA_REG_DOWNSAMPLE_HI: read_mux = cfg.downsample[15:8];
         `LA_REG_ARM:           read_mux = {7'b0, cfg.arm};
         `LA_REG_MANUAL:        read_mux = {7'b0, cfg.manual};
         `LA_REG_STATUS:        read_mux = {5'b0, cfg.arm, overflow, capturing};
         default:               read_mux = '0;
      endcase
   end

   // Request/acknowledge sequencing
   always_ff @(posedge observer_clk) begin
      if (reset) begin
         state   <= la_pkg::IDLE;
         reg_ack <= 1'b0;
      end else begin
         case (state)
            la_pkg::IDLE: begin
               if (reg_req) begin
                  reg_ack <= 1'b1;
                  state   <= la_pkg::ACK;
               end
            end
            default: begin
               if (!reg_req) begin   // Master has seen the ack
                  reg_ack <= 1'b0;
                  state   <= la_pkg::IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge observer_clk) begin
      if (do_access && !reg_we)
         reg_rdata <= read_mux;
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         cfg.group      <= '0;
         cfg.trig_sel   <= '0;
         cfg.depth      <= '0;
         cfg.downsample <= '0;
         cfg.arm        <= 1'b0;
         cfg.manual     <= 1'b0;
         arm_write      <= 1'b0;
      end else begin
         arm_write <= 1'b0;
         if (capture_start)
            cfg.arm <= 1'b0;        // One capture per arm
         if (do_access && reg_we) begin
            case (reg_addr)
               `LA_REG_GROUP:         cfg.group <= reg_wdata[2:0];
               `LA_REG_TRIGGER:       cfg.trig_sel <= reg_wdata;
               `LA_REG_DEPTH_LO:      cfg.depth[7:0] <= reg_wdata;
               `LA_REG_DEPTH_HI:      cfg.depth[15:8] <= reg_wdata;
               `LA_REG_DOWNSAMPLE_LO: cfg.downsample[7:0] <= reg_wdata;
               `LA_REG_DOWNSAMPLE_HI: cfg.downsample[15:8] <= reg_wdata;
               `LA_REG_ARM: begin
                  cfg.arm   <= reg_wdata[0];
                  arm_write <= reg_wdata[0];   // Clears overflow
               end
               `LA_REG_MANUAL:        cfg.manual <= reg_wdata[0];
               default: ;                      // Status is read only
            endcase
         end
      end
   end

endmodule

/* hw/la_trigger.sv */
`timescale 1ns/1ps
`include "la_config.svh"

module la_trigger (
   input  logic               observer_clk,
   input  logic               reset,
   input  la_pkg::probe_bus_t probes,
   la_cfg_if.trig             cfg,
   input  logic               capturing,
   output logic               capture_start
);

   logic [1:0]                 trig_group;
   logic [3:0]                 trig_lane;
   logic                       probe_bit;
   logic                       trig_src;
   logic [`LA_SYNC_STAGES-1:0] sync_pipe;
   logic                       sync_prev;   // Edge register

   assign trig_group = cfg.trig_sel[`LA_TRIG_GROUP_MSB:`LA_TRIG_GROUP_LSB];
   assign trig_lane  = cfg.trig_sel[`LA_TRIG_LANE_MSB:`LA_TRIG_LANE_LSB];

   always_comb begin
      if (trig_lane < `LA_NUM_LANES)
         probe_bit = probes[int'(trig_group) * `LA_NUM_LANES + int'(trig_lane)];
      else
         probe_bit = 1'b0;   // Lanes 9..15 do not exist
   end

   // Polarity first, then manual on top
   assign trig_src = (probe_bit ^ cfg.trig_sel[`LA_TRIG_INVERT]) | cfg.manual;

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         sync_pipe     <= '0;
         sync_prev     <= 1'b0;
         capture_start <= 1'b0;
      end else begin
         sync_pipe <= {sync_pipe[`LA_SYNC_STAGES-2:0], trig_src};
         sync_prev <= sync_pipe[`LA_SYNC_STAGES-1];

         // Rising edge, armed, and no capture already running
         capture_start <= sync_pipe[`LA_SYNC_STAGES-1] & ~sync_prev
                          & cfg.arm & ~capturing;
      end
   end

endmodule

/* hw/la_capture_ctrl.sv */
`timescale 1ns/1ps

module la_capture_ctrl (
   input  logic   observer_clk,
   input  logic   reset,
   input  logic   capture_start,
   la_cfg_if.ctrl cfg,
   output logic   capturing,
   output logic   sample_strobe,
   output logic   word_strobe
);

   la_pkg::count16_t ds_count;       // Cycles since last strobe
   la_pkg::count16_t strobe_count;   // Strobes so far in this capture
   logic             pair_phase;     // High on every second strobe
   logic             last_strobe;

   // Plain decimation, one strobe every downsample+1 cycles
   assign sample_strobe = capturing && (ds_count == cfg.downsample);

   // A zero depth still takes one strobe
   assign last_strobe = (strobe_count == cfg.depth - 16'd1) || (cfg.depth == '0);

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         capturing    <= 1'b0;
         ds_count     <= '0;
         strobe_count <= '0;
         pair_phase   <= 1'b0;
         word_strobe  <= 1'b0;
      end else begin
         // Lanes have shifted by the time this is seen
         word_strobe <= sample_strobe && pair_phase;

         if (capture_start) begin
            capturing    <= 1'b1;
            ds_count     <= '0;
            strobe_count <= '0;
            pair_phase   <= 1'b0;
         end else if (capturing) begin
            if (sample_strobe) begin
               ds_count     <= '0;
               strobe_count <= strobe_count + 16'd1;
               pair_phase   <= ~pair_phase;
               if (last_strobe)
                  capturing <= 1'b0;
            end else begin
               ds_count <= ds_count + 16'd1;
            end
         end
      end
   end

endmodule

/* hw/la_lane.sv */
`timescale 1ns/1ps
`include "la_config.svh"

module la_lane #(
   parameter int LANE = 0
) (
   input  logic               observer_clk,
   input  logic               reset,
   input  la_pkg::group_sel_t group,
   input  la_pkg::probe_bus_t probes,
   input  logic               sample_strobe,
   output la_pkg::lane_hist_t hist
);

   logic lane_src;

   // Source bit registered every cycle, strobe or not
   always_ff @(posedge observer_clk) begin
      if (group < `LA_NUM_GROUPS)
         lane_src <= probes[int'(group) * `LA_NUM_LANES + LANE];
      else
         lane_src <= (LANE % 2 == 0);   // Pattern, 1 on even lanes
   end

   always_ff @(posedge observer_clk) begin
      if (reset)
         hist <= '0;
      else if (sample_strobe)
         hist <= {hist[0], lane_src};   // Older sample moves up
   end

endmodule

/* hw/la_word_writer.sv */
`timescale 1ns/1ps

module la_word_writer (
   input  logic                 observer_clk,
   input  logic                 reset,
   input  logic                 word_strobe,
   input  la_pkg::sample_word_t lane_hists,
   input  logic                 arm_write,
   output logic                 word_req,
   output la_pkg::sample_word_t word_data,
   input  logic                 word_ack,
   output logic                 overflow
);

   la_pkg::hs_state_t state;
   logic              port_busy;

   // Port is free only with both req and ack low
   assign port_busy = word_req || word_ack;

   // Word held for the whole handshake
   always_ff @(posedge observer_clk) begin
      if (word_strobe && !port_busy)
         word_data <= lane_hists;
   end

   always_ff @(posedge observer_clk) begin
      if (reset) begin
         state    <= la_pkg::IDLE;
         word_req <= 1'b0;
      end else if (word_strobe && !port_busy) begin
         word_req <= 1'b1;
         state    <= la_pkg::ACK;       // Wait for the sink's ack
      end else begin
         case (state)
            la_pkg::ACK: begin
               if (word_ack) begin
                  word_req <= 1'b0;
                  state    <= la_pkg::WAIT_REQ_LOW;
               end
            end
            la_pkg::WAIT_REQ_LOW: begin
               if (!word_ack)            // Sink saw req low
                  state <= la_pkg::IDLE;
            end
            default: ;
         endcase
      end
   end

   // Sampling never stalls, so a busy port drops the word
   always_ff @(posedge observer_clk) begin
      if (reset)
         overflow <= 1'b0;
      else if (word_strobe && port_busy)
         overflow <= 1'b1;
      else if (arm_write)
         overflow <= 1'b0;
   end

endmodule

/* hw/la_top.sv */
`timescale 1ns/1ps
`include "la_config.svh"

module la_top (
   input  logic                     observer_clk,
   input  logic                     reset,
   input  logic [`LA_NUM_LANES-1:0] probe_a,
   input  logic [`LA_NUM_LANES-1:0] probe_b,
   input  logic [`LA_NUM_LANES-1:0] probe_c,
   input  logic [`LA_NUM_LANES-1:0] probe_d,
   input  logic                     reg_req,
   input  logic                     reg_we,
   input  la_pkg::reg_addr_t        reg_addr,
   input  la_pkg::reg_data_t        reg_wdata,
   output logic                     reg_ack,
   output la_pkg::reg_data_t        reg_rdata,
   output logic                     word_req,
   output la_pkg::sample_word_t     word_data,
   input  logic                     word_ack
);

   la_pkg::probe_bus_t   probes;
   la_pkg::sample_word_t lane_hists;
   logic                 capturing;
   logic                 capture_start;
   logic                 sample_strobe;
   logic                 word_strobe;
   logic                 overflow;
   logic                 arm_write;

   la_cfg_if cfg_if ();

   assign probes = {probe_d, probe_c, probe_b, probe_a};   // Group 0 in the low bits

   la_regs la_regs_inst (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .reg_req       (reg_req),
      .reg_we        (reg_we),
      .reg_addr      (reg_addr),
      .reg_wdata     (reg_wdata),
      .reg_ack       (reg_ack),
      .reg_rdata     (reg_rdata),
      .cfg           (cfg_if.regs),
      .capturing     (capturing),
      .capture_start (capture_start),
      .overflow      (overflow),
      .arm_write     (arm_write)
   );

   la_trigger la_trigger_inst (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .probes        (probes),
      .cfg           (cfg_if.trig),
      .capturing     (capturing),
      .capture_start (capture_start)
   );

   la_capture_ctrl la_capture_ctrl_inst (
      .observer_clk  (observer_clk),
      .reset         (reset),
      .capture_start (capture_start),
      .cfg           (cfg_if.ctrl),
      .capturing     (capturing),
      .sample_strobe (sample_strobe),
      .word_strobe   (word_strobe)
   );

   for (genvar i = 0; i < `LA_NUM_LANES; i++) begin : g_lane
      la_lane #(
         .LANE (i)
      ) la_lane_inst (
         .observer_clk  (observer_clk),
         .reset         (reset),
         .group         (cfg_if.group),
         .probes        (probes),
         .sample_strobe (sample_strobe),
         .hist          (lane_hists[2*i +: 2])
      );
   end

   la_word_writer la_word_writer_inst (
      .observer_clk (observer_clk),
      .reset        (reset),
      .word_strobe  (word_strobe),
      .lane_hists   (lane_hists),
      .arm_write    (arm_write),
      .word_req     (word_req),
      .word_data    (word_data),
      .word_ack     (word_ack),
      .overflow     (overflow)
   );

endmodule

/* tb/la_clock_gen.sv */
`timescale 1ns/1ps

module la_clock_gen #(
   parameter int HALF_PERIOD = 50   // 100 ns period
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

endmodule

/* tb/la_tb.sv */
`timescale 1ns/1ps
`include "la_config.svh"

module la_tb;

   localparam int REG_TIMEOUT  = 20;    // Cycles per handshake phase
   localparam int WORD_TIMEOUT = 200;

   // Rough cycle cost of each test
   localparam int REGISTER_CYCLES   = 80;
   localparam int STATIC_CYCLES     = 4 * 100;
   localparam int PATTERN_CYCLES    = 200;
   localparam int ARMING_CYCLES     = 250;
   localparam int DOWNSAMPLE_CYCLES = 150;
   localparam int OVERFLOW_CYCLES   = 150;
   localparam int WATCHDOG_CYCLES   = REGISTER_CYCLES + STATIC_CYCLES + PATTERN_CYCLES
                                      + ARMING_CYCLES + DOWNSAMPLE_CYCLES
                                      + OVERFLOW_CYCLES + 500;

   logic                     observer_clk;
   logic                     reset;
   logic [`LA_NUM_LANES-1:0] probe_a;
   logic [`LA_NUM_LANES-1:0] probe_b;
   logic [`LA_NUM_LANES-1:0] probe_c;
   logic [`LA_NUM_LANES-1:0] probe_d;
   logic                     reg_req;
   logic                     reg_we;
   la_pkg::reg_addr_t        reg_addr;
   la_pkg::reg_data_t        reg_wdata;
   logic                     reg_ack;
   la_pkg::reg_data_t        reg_rdata;
   logic                     word_req;
   la_pkg::sample_word_t     word_data;
   logic                     word_ack;

   la_pkg::sample_word_t words[$];        // Every word offered on the port
   int                   rise_cycles[$];  // Cycle of each word_req rise
   int                   cycle = 0;
   bit                   sink_enable = 1'b1;

   la_clock_gen clock_gen_inst (
      .clk (observer_clk)
   );

   la_top la_top_inst (
      .observer_clk (observer_clk),
      .reset        (reset),
      .probe_a      (probe_a),
      .probe_b      (probe_b),
      .probe_c      (probe_c),
      .probe_d      (probe_d),
      .reg_req      (reg_req),
      .reg_we       (reg_we),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_ack      (reg_ack),
      .reg_rdata    (reg_rdata),
      .word_req     (word_req),
      .word_data    (word_data),
      .word_ack     (word_ack)
   );

   always @(posedge observer_clk)
      cycle <= cycle + 1;

   task automatic fail(string what);
      $display("%s", what);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check(string name, logic [31:0] got, logic [31:0] expected);
      if (got !== expected) begin
         $display("Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
         $display("test failed");
         $fatal(1);
      end
   endtask

   task automatic wait_cycles(int n);
      repeat (n) @(negedge observer_clk);
   endtask

   // Four-phase register access with one request per call
   task automatic reg_access(input la_pkg::reg_addr_t addr, input logic we,
                             input la_pkg::reg_data_t wdata,
                             output la_pkg::reg_data_t rdata);
      int waited;
      @(negedge observer_clk);
      reg_addr  = addr;
      reg_we    = we;
      reg_wdata = wdata;
      reg_req   = 1'b1;
      waited    = 0;
      while (!reg_ack) begin
         @(negedge observer_clk);
         waited++;
         if (waited > REG_TIMEOUT)
            fail("Register port never raised reg_ack");
      end
      rdata   = reg_rdata;
      reg_req = 1'b0;
      waited  = 0;
      while (reg_ack) begin
         @(negedge observer_clk);
         waited++;
         if (waited > REG_TIMEOUT)
            fail("Register port never dropped reg_ack");
      end
      reg_we = 1'b0;
   endtask

   task automatic reg_write(la_pkg::reg_addr_t addr, la_pkg::reg_data_t data);
      la_pkg::reg_data_t unused;
      reg_access(addr, 1'b1, data, unused);
   endtask

   task automatic reg_read(input la_pkg::reg_addr_t addr, output la_pkg::reg_data_t data);
      reg_access(addr, 1'b0, 8'h00, data);
   endtask

   // Records each offered word and acks it within a cycle when enabled
   task automatic run_sink();
      logic req_seen;
      word_ack = 1'b0;
      req_seen = 1'b0;
      forever begin
         @(negedge observer_clk);
         if (word_req && !req_seen) begin
            words.push_back(word_data);
            rise_cycles.push_back(cycle);
         end
         req_seen = word_req;
         if (word_ack && !word_req)
            word_ack = 1'b0;
         else if (sink_enable && word_req)
            word_ack = 1'b1;
      end
   endtask

   task automatic configure(la_pkg::group_sel_t group, la_pkg::trig_sel_t trig,
                            la_pkg::count16_t depth, la_pkg::count16_t downsample);
      reg_write(`LA_REG_GROUP, {5'b0, group});
      reg_write(`LA_REG_TRIGGER, trig);
      reg_write(`LA_REG_DEPTH_LO, depth[7:0]);
      reg_write(`LA_REG_DEPTH_HI, depth[15:8]);
      reg_write(`LA_REG_DOWNSAMPLE_LO, downsample[7:0]);
      reg_write(`LA_REG_DOWNSAMPLE_HI, downsample[15:8]);
   endtask

   // Group 0 lane 0 with invert equal to the probe so the source sits low
   function automatic la_pkg::trig_sel_t low_trigger();
      return {probe_a[0], 7'b0};
   endfunction

   // Both history bits of a lane equal its source bit for static probes
   function automatic la_pkg::sample_word_t expected_word(int g);
      la_pkg::probe_bus_t   probes;
      la_pkg::sample_word_t word;
      probes = {probe_d, probe_c, probe_b, probe_a};
      for (int i = 0; i < `LA_NUM_LANES; i++) begin
         if (g < `LA_NUM_GROUPS)
            word[2*i +: 2] = {2{probes[9*g + i]}};
         else
            word[2*i +: 2] = (i % 2 == 0) ? 2'b11 : 2'b00;   // Fixed pattern
      end
      return word;
   endfunction

   task automatic finish_capture(int base, int word_count, int group);
      la_pkg::reg_data_t data;
      int                waited;
      waited = 0;
      while (words.size() < base + word_count) begin
         @(negedge observer_clk);
         waited++;
         if (waited > WORD_TIMEOUT)
            fail("Expected words never arrived on the word port");
      end
      waited = 0;
      data   = 8'h01;
      while (data[0]) begin
         reg_read(`LA_REG_STATUS, data);
         waited++;
         if (waited > REG_TIMEOUT)
            fail("Capture never ended");
      end
      wait_cycles(4);   // Room for a stray extra word
      check("word count", 32'(words.size() - base), 32'(word_count));
      for (int k = base; k < base + word_count; k++)
         check("word_data", 32'(words[k]), 32'(expected_word(group)));
   endtask

   task automatic manual_capture(int word_count, int group);
      la_pkg::reg_data_t data;
      int                base;
      base = words.size();
      reg_write(`LA_REG_ARM, 8'h01);
      reg_write(`LA_REG_MANUAL, 8'h01);
      reg_write(`LA_REG_MANUAL, 8'h00);
      finish_capture(base, word_count, group);
      reg_read(`LA_REG_ARM, data);
      check("arm", 32'(data), 32'h0);
   endtask

   task automatic register_access();
      la_pkg::reg_addr_t addrs[6] = '{`LA_REG_GROUP, `LA_REG_TRIGGER, `LA_REG_DEPTH_LO,
                                      `LA_REG_DEPTH_HI, `LA_REG_DOWNSAMPLE_LO,
                                      `LA_REG_DOWNSAMPLE_HI};
      la_pkg::reg_data_t values[6] = '{8'h03, 8'ha5, 8'h34, 8'h12, 8'h56, 8'h07};
      la_pkg::reg_data_t data;
      reg_read(`LA_REG_STATUS, data);
      check("status", 32'(data), 32'h0);
      for (int i = 0; i < 6; i++)
         reg_write(addrs[i], values[i]);
      for (int i = 0; i < 6; i++) begin
         reg_read(addrs[i], data);
         check($sformatf("reg_rdata at address %0d", addrs[i]), 32'(data), 32'(values[i]));
      end
   endtask

   task automatic static_probe_capture();
      for (int g = 0; g < `LA_NUM_GROUPS; g++) begin
         configure(3'(g), low_trigger(), 16'd8, 16'd0);
         manual_capture(4, g);
      end
   endtask

   task automatic pattern_and_polarity();
      la_pkg::reg_data_t data;
      int                base;
      configure(3'd5, low_trigger(), 16'd4, 16'd0);
      manual_capture(2, 5);
      @(negedge observer_clk);
      probe_c[5] = 1'b0;
      configure(3'd0, 8'ha5, 16'd2, 16'd0);   // Inverted trigger on group 2 lane 5
      base = words.size();
      reg_write(`LA_REG_ARM, 8'h01);
      @(negedge observer_clk);
      probe_c[5] = 1'b1;   // Rising probe is a falling source
      wait_cycles(12);
      reg_read(`LA_REG_STATUS, data);
      check("status", 32'(data), 32'h4);
      check("word count", 32'(words.size() - base), 32'h0);
      probe_c[5] = 1'b0;
      finish_capture(base, 1, 0);
   endtask

   task automatic arming_rules();
      la_pkg::reg_data_t data;
      int                base;
      @(negedge observer_clk);
      probe_b[3] = 1'b0;
      configure(3'd0, 8'h13, 16'd2, 16'd3);   // Group 1 lane 3 with an 8-cycle capture
      base = words.size();
      @(negedge observer_clk);
      probe_b[3] = 1'b1;   // Not armed yet
      wait_cycles(12);
      check("word count", 32'(words.size() - base), 32'h0);
      probe_b[3] = 1'b0;
      wait_cycles(4);
      reg_write(`LA_REG_ARM, 8'h01);
      @(negedge observer_clk);
      probe_b[3] = 1'b1;
      wait_cycles(2);
      probe_b[3] = 1'b0;
      wait_cycles(2);
      probe_b[3] = 1'b1;   // Second edge lands inside the capture
      finish_capture(base, 1, 0);
      probe_b[3] = 1'b0;
      wait_cycles(4);
      probe_b[3] = 1'b1;   // And one after it
      wait_cycles(20);
      check("word count", 32'(words.size() - base), 32'h1);
      reg_read(`LA_REG_STATUS, data);
      check("status", 32'(data), 32'h0);
      reg_write(`LA_REG_ARM, 8'h01);
      @(negedge observer_clk);
      probe_b[3] = 1'b0;
      wait_cycles(4);
      probe_b[3] = 1'b1;
      finish_capture(base, 2, 0);
   endtask

   task automatic downsample_spacing();
      int base;
      configure(3'd0, low_trigger(), 16'd8, 16'd3);
      base = words.size();
      manual_capture(4, 0);
      for (int k = base + 1; k < base + 4; k++)
         check("word_req spacing", 32'(rise_cycles[k] - rise_cycles[k-1]), 32'd8);
   endtask

   task automatic overflow_handling();
      la_pkg::reg_data_t data;
      int                base;
      configure(3'd0, low_trigger(), 16'd8, 16'd0);
      base        = words.size();
      sink_enable = 1'b0;   // Sink holds off ack
      reg_write(`LA_REG_ARM, 8'h01);
      reg_write(`LA_REG_MANUAL, 8'h01);
      reg_write(`LA_REG_MANUAL, 8'h00);
      wait_cycles(20);
      reg_read(`LA_REG_STATUS, data);
      check("status", 32'(data), 32'h2);
      check("word_req", 32'(word_req), 32'h1);   // First word still held
      sink_enable = 1'b1;
      wait_cycles(8);
      check("word_req", 32'(word_req), 32'h0);
      check("word count", 32'(words.size() - base), 32'h1);   // Later words dropped
      check("word_data", 32'(words[base]), 32'(expected_word(0)));
      reg_write(`LA_REG_ARM, 8'h01);   // Clears overflow
      reg_read(`LA_REG_STATUS, data);
      check("status", 32'(data), 32'h4);
      reg_write(`LA_REG_ARM, 8'h00);
      reg_read(`LA_REG_STATUS, data);
      check("status", 32'(data), 32'h0);
   endtask

   initial run_sink();

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge observer_clk);
      $display("Run went past %0d cycles without finishing", WATCHDOG_CYCLES);
      $display("test failed");
      $fatal(1);
   end

   initial begin
      void'($urandom(32'hf6e0_3940));
      reset     = 1'b1;
      reg_req   = 1'b0;
      reg_we    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      probe_a   = 9'($urandom);
      probe_b   = 9'($urandom);
      probe_c   = 9'($urandom);
      probe_d   = 9'($urandom);
      repeat (3) @(negedge observer_clk);
      reset = 1'b0;

      register_access();
      static_probe_capture();
      pattern_and_polarity();
      arming_rules();
      downsample_spacing();
      overflow_handling();

      $display("test passed");
      $finish;
   end

endmodule

/* la_capture.f */
+incdir+hw
hw/la_pkg.sv
hw/la_if.sv
hw/la_regs.sv
hw/la_trigger.sv
hw/la_capture_ctrl.sv
hw/la_lane.sv
hw/la_word_writer.sv
hw/la_top.sv
tb/la_clock_gen.sv
tb/la_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the capture engine testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module la_tb -Mdir obj_dir -f la_capture.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/Vla_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "test passed"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
